/* design/dpu_alu_array.sv */
`include "dpu_config.svh"

module dpu_alu_array
   import dpu_data_pkg::*, dpu_op_pkg::*;
(
   input  logic                           clk_i,
   input  logic                           rst_i,
   input  logic                           alu_vld_i,
   input  alu_op_t                        alu_op_i,
   input  sew_t                           alu_sew_i,
   input  lane_word_t [`DPU_LANES-1:0]    alu_a_i,
   input  lane_word_t [`DPU_LANES-1:0]    alu_b_i,
   output logic                           res_vld_o,
   output lane_word_t [`DPU_LANES-1:0]    res_o,
   output sew_t                           res_sew_o
);

   // Byte-sliced adder, carry restarts at each element boundary
   function automatic lane_word_t add_sub(input lane_word_t a, input lane_word_t b,
                                          input logic sub, input sew_t sew);
      lane_word_t bx;
      lane_word_t res;
      logic [8:0] sum;
      logic       carry;
      bx    = sub ? ~b : b;   // Two's complement, +1 via carry in
      carry = sub;
      for (int k = 0; k < 4; k++)
      begin
         if (sew == SEW_8 || (sew == SEW_16 && k == 2))
            carry = sub;   // Element start
         sum            = a[k*8 +: 8] + bx[k*8 +: 8] + carry;
         res[k*8 +: 8]  = sum[7:0];
         carry          = sum[8];
      end
      return res;
   endfunction

   // One ALU unit
   function automatic lane_word_t alu_unit(input lane_word_t a, input lane_word_t b,
                                           input alu_op_t op, input sew_t sew);
      case (op)
         OP_ADD:  return add_sub(a, b, 1'b0, sew);
         OP_SUB:  return add_sub(a, b, 1'b1, sew);
         OP_AND:  return a & b;
         OP_OR:   return a | b;
         OP_XOR:  return a ^ b;
         default: return '0;
      endcase
   endfunction

   ////////////////////////////////////////////////////////////
   // Unit bank and output register
   ////////////////////////////////////////////////////////////

   lane_word_t [`DPU_LANES-1:0] unit_res;

   always_comb
   begin
      for (int u = 0; u < `DPU_LANES; u++)
         unit_res[u] = alu_unit(alu_a_i[u], alu_b_i[u], alu_op_i, alu_sew_i);
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
         res_vld_o <= 1'b0;
      else
         res_vld_o <= alu_vld_i;
   end

   // Payload only loads on a valid op
   always_ff @(posedge clk_i)
   begin
      if (alu_vld_i)
      begin
         res_o     <= unit_res;
         res_sew_o <= alu_sew_i;   // Scatter needs the layout
      end
   end

endmodule

/* design/dpu_config.svh */
`ifndef DPU_CONFIG_SVH
`define DPU_CONFIG_SVH

////////////////////////////////////////////////////////////
// Lane array geometry
////////////////////////////////////////////////////////////

`define DPU_LANES      8   // Lanes in the array
`define DPU_WORD       32  // Bits per lane word
`define DPU_LANE_IDX_W 3   // Bits to number a lane

////////////////////////////////////////////////////////////
// Issue timing and field widths
////////////////////////////////////////////////////////////

`define DPU_VRF_DELAY  3   // Issue to lane words present
`define DPU_IMM_W      5   // Immediate field
`define DPU_OP_W       3   // Opcode field
`define DPU_SEL_W      2   // Operand select and SEW fields

`endif

/* design/dpu_data_pkg.sv */
`include "dpu_config.svh"

package dpu_data_pkg;

   ////////////////////////////////////////////////////////////
   // Data path types
   ////////////////////////////////////////////////////////////

   typedef logic [`DPU_WORD-1:0]       lane_word_t;  // One lane word
   typedef logic [7:0]                 lane_byte_t;
   typedef logic [`DPU_LANE_IDX_W-1:0] lane_idx_t;   // Lane number
   typedef logic [`DPU_SEL_W-1:0]      sew_t;

   // Element width codes, 3 is illegal
   localparam sew_t SEW_8  = 2'd0;
   localparam sew_t SEW_16 = 2'd1;
   localparam sew_t SEW_32 = 2'd2;

endpackage

/* design/dpu_lane_array.sv */
`include "dpu_config.svh"

module dpu_lane_array
   import dpu_data_pkg::*, dpu_op_pkg::*;
(
   input  logic                           clk_i,
   input  logic                           rst_i,
   input  logic                           issue_i,
   input  alu_op_t                        op_i,
   input  sew_t                           sew_i,
   input  op2_sel_t                       op2_sel_i,
   input  lane_word_t                     scalar_i,
   input  imm_t                           imm_i,
   input  logic                           slide_up_i,
   input  lane_word_t [`DPU_LANES-1:0]    vs1_i,
   input  lane_word_t [`DPU_LANES-1:0]    vs2_i,
   output logic                           result_valid_o,
   output lane_word_t [`DPU_LANES-1:0]    result_o
);

   // Operand stage to ALU bank
   logic                        alu_vld;
   alu_op_t                     alu_op;
   sew_t                        alu_sew;
   lane_word_t [`DPU_LANES-1:0] alu_a;
   lane_word_t [`DPU_LANES-1:0] alu_b;

   // Operand stage to slide crossbar
   logic                        slide_vld;
   lane_word_t [`DPU_LANES-1:0] slide_data;
   lane_idx_t                   slide_amt;
   logic [1:0]                  slide_byte;
   logic                        slide_up;

   // Registered results into the scatter
   logic                        res_vld;
   lane_word_t [`DPU_LANES-1:0] res;
   sew_t                        res_sew;
   logic                        slide_res_vld;
   lane_word_t [`DPU_LANES-1:0] slide_res;

   dpu_operand_stage u_operand_stage (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .issue_i      (issue_i),
      .op_i         (op_i),
      .sew_i        (sew_i),
      .op2_sel_i    (op2_sel_i),
      .scalar_i     (scalar_i),
      .imm_i        (imm_i),
      .slide_up_i   (slide_up_i),
      .vs1_i        (vs1_i),
      .vs2_i        (vs2_i),
      .alu_vld_o    (alu_vld),
      .alu_op_o     (alu_op),
      .alu_sew_o    (alu_sew),
      .alu_a_o      (alu_a),
      .alu_b_o      (alu_b),
      .slide_vld_o  (slide_vld),
      .slide_data_o (slide_data),
      .slide_amt_o  (slide_amt),
      .slide_byte_o (slide_byte),
      .slide_up_o   (slide_up)
   );

   dpu_alu_array u_alu_array (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .alu_vld_i (alu_vld),
      .alu_op_i  (alu_op),
      .alu_sew_i (alu_sew),
      .alu_a_i   (alu_a),
      .alu_b_i   (alu_b),
      .res_vld_o (res_vld),
      .res_o     (res),
      .res_sew_o (res_sew)
   );

   dpu_slide_xbar u_slide_xbar (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .slide_vld_i  (slide_vld),
      .slide_data_i (slide_data),
      .slide_amt_i  (slide_amt),
      .slide_byte_i (slide_byte),
      .slide_up_i   (slide_up),
      .slide_vld_o  (slide_res_vld),
      .slide_res_o  (slide_res)
   );

   dpu_result_scatter u_result_scatter (
      .res_vld_i      (res_vld),
      .res_i          (res),
      .res_sew_i      (res_sew),
      .slide_vld_i    (slide_res_vld),
      .slide_res_i    (slide_res),
      .result_valid_o (result_valid_o),
      .result_o       (result_o)
   );

endmodule

/* design/dpu_op_pkg.sv */
`include "dpu_config.svh"

package dpu_op_pkg;

   ////////////////////////////////////////////////////////////
   // Operation types
   ////////////////////////////////////////////////////////////

   typedef logic [`DPU_OP_W-1:0]  alu_op_t;
   typedef logic [`DPU_SEL_W-1:0] op2_sel_t;  // Second operand source
   typedef logic [`DPU_IMM_W-1:0] imm_t;

   // Opcodes
   localparam alu_op_t OP_ADD   = 3'd0;
   localparam alu_op_t OP_SUB   = 3'd1;  // vs1 minus op2
   localparam alu_op_t OP_AND   = 3'd2;
   localparam alu_op_t OP_OR    = 3'd3;
   localparam alu_op_t OP_XOR   = 3'd4;
   localparam alu_op_t OP_SLIDE = 3'd5;  // Goes to the slide crossbar

   // Second operand selects
   localparam op2_sel_t OP2_VEC    = 2'd0;
   localparam op2_sel_t OP2_SCALAR = 2'd1;
   localparam op2_sel_t OP2_IMM    = 2'd2;

endpackage

/* design/dpu_operand_stage.sv */
`include "dpu_config.svh"

module dpu_operand_stage
   import dpu_data_pkg::*, dpu_op_pkg::*;
(
   input  logic                           clk_i,
   input  logic                           rst_i,
   input  logic                           issue_i,
   input  alu_op_t                        op_i,
   input  sew_t                           sew_i,
   input  op2_sel_t                       op2_sel_i,
   input  lane_word_t                     scalar_i,
   input  imm_t                           imm_i,
   input  logic                           slide_up_i,
   input  lane_word_t [`DPU_LANES-1:0]    vs1_i,
   input  lane_word_t [`DPU_LANES-1:0]    vs2_i,
   output logic                           alu_vld_o,
   output alu_op_t                        alu_op_o,
   output sew_t                           alu_sew_o,
   output lane_word_t [`DPU_LANES-1:0]    alu_a_o,
   output lane_word_t [`DPU_LANES-1:0]    alu_b_o,
   output logic                           slide_vld_o,
   output lane_word_t [`DPU_LANES-1:0]    slide_data_o,
   output lane_idx_t                      slide_amt_o,
   output logic [1:0]                     slide_byte_o,
   output logic                           slide_up_o
);

   // Unit u byte j, pulled from the lane layout. At SEW 16 a unit carries
   // two elements, byte positions u/4 and u/4+2 of the same lane pair
   function automatic lane_word_t gather(input lane_word_t [`DPU_LANES-1:0] w,
                                         input sew_t sew, input int u);
      lane_word_t e;
      int src_l;
      int src_b;
      for (int j = 0; j < 4; j++)
      begin
         case (sew)
            SEW_16:
            begin
               src_l = 2 * (u % 4) + j % 2;
               src_b = u / 4 + 2 * (j / 2);
            end
            SEW_32:
            begin
               src_l = 4 * (u % 2) + j;   // Low byte from lowest lane
               src_b = u / 2;
            end
            default:
            begin
               src_l = u;
               src_b = j;
            end
         endcase
         e[j*8 +: 8] = w[src_l][src_b*8 +: 8];
      end
      return e;
   endfunction

   // Copy the low SEW bits into every element of a word
   function automatic lane_word_t splat(input lane_word_t v, input sew_t sew);
      case (sew)
         SEW_16:  return {2{v[15:0]}};
         SEW_32:  return v;
         default: return {4{v[7:0]}};
      endcase
   endfunction

   ////////////////////////////////////////////////////////////
   // Issue field delay line, matches the VRF read latency
   ////////////////////////////////////////////////////////////

   logic [`DPU_VRF_DELAY-1:0] vld_q;
   alu_op_t                   op_q      [`DPU_VRF_DELAY];
   sew_t                      sew_q     [`DPU_VRF_DELAY];
   op2_sel_t                  op2_sel_q [`DPU_VRF_DELAY];
   lane_word_t                scalar_q  [`DPU_VRF_DELAY];
   imm_t                      imm_q     [`DPU_VRF_DELAY];
   logic                      up_q      [`DPU_VRF_DELAY];

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
         vld_q <= '0;
      else
         vld_q <= {vld_q[`DPU_VRF_DELAY-2:0], issue_i};
   end

   always_ff @(posedge clk_i)
   begin
      op_q[0]      <= op_i;
      sew_q[0]     <= sew_i;
      op2_sel_q[0] <= op2_sel_i;
      scalar_q[0]  <= scalar_i;
      imm_q[0]     <= imm_i;
      up_q[0]      <= slide_up_i;
      for (int s = 1; s < `DPU_VRF_DELAY; s++)
      begin
         op_q[s]      <= op_q[s-1];
         sew_q[s]     <= sew_q[s-1];
         op2_sel_q[s] <= op2_sel_q[s-1];
         scalar_q[s]  <= scalar_q[s-1];
         imm_q[s]     <= imm_q[s-1];
         up_q[s]      <= up_q[s-1];
      end
   end

   ////////////////////////////////////////////////////////////
   // Operands, valid split by opcode
   ////////////////////////////////////////////////////////////

   alu_op_t    op_d;
   sew_t       sew_d;
   lane_word_t imm_ext;

   assign op_d    = op_q[`DPU_VRF_DELAY-1];
   assign sew_d   = sew_q[`DPU_VRF_DELAY-1];
   assign imm_ext = lane_word_t'(imm_q[`DPU_VRF_DELAY-1]);   // Zero extend

   assign alu_vld_o   = vld_q[`DPU_VRF_DELAY-1] && (op_d != OP_SLIDE);
   assign slide_vld_o = vld_q[`DPU_VRF_DELAY-1] && (op_d == OP_SLIDE);
   assign alu_op_o    = op_d;
   assign alu_sew_o   = sew_d;

   always_comb
   begin
      for (int u = 0; u < `DPU_LANES; u++)
      begin
         alu_a_o[u] = gather(vs1_i, sew_d, u);
         case (op2_sel_q[`DPU_VRF_DELAY-1])
            OP2_SCALAR: alu_b_o[u] = splat(scalar_q[`DPU_VRF_DELAY-1], sew_d);
            OP2_IMM:    alu_b_o[u] = splat(imm_ext, sew_d);
            default:    alu_b_o[u] = gather(vs2_i, sew_d, u);   // OP2_VEC
         endcase
      end
   end

   // Slide path sees raw lane words
   assign slide_data_o = vs2_i;
   assign slide_amt_o  = scalar_q[`DPU_VRF_DELAY-1][`DPU_LANE_IDX_W-1:0];
   assign slide_byte_o = imm_q[`DPU_VRF_DELAY-1][1:0];
   assign slide_up_o   = up_q[`DPU_VRF_DELAY-1];

endmodule

/* design/dpu_result_scatter.sv */
`include "dpu_config.svh"

module dpu_result_scatter
   import dpu_data_pkg::*;
(
   input  logic                           res_vld_i,
   input  lane_word_t [`DPU_LANES-1:0]    res_i,
   input  sew_t                           res_sew_i,
   input  logic                           slide_vld_i,
   input  lane_word_t [`DPU_LANES-1:0]    slide_res_i,
   output logic                           result_valid_o,
   output lane_word_t [`DPU_LANES-1:0]    result_o
);

   ////////////////////////////////////////////////////////////
   // Inverse of the operand gathering
   ////////////////////////////////////////////////////////////

   lane_word_t [`DPU_LANES-1:0] scattered;

   // For lane l byte b find unit u and its byte j
   always_comb
   begin
      int u;
      int j;
      for (int l = 0; l < `DPU_LANES; l++)
      begin
         for (int b = 0; b < 4; b++)
         begin
            case (res_sew_i)
               SEW_16:
               begin
                  u = l / 2 + 4 * (b % 2);
                  j = l % 2 + 2 * (b / 2);
               end
               SEW_32:
               begin
                  u = 2 * b + l / 4;
                  j = l % 4;
               end
               default:
               begin
                  u = l;   // SEW 8 keeps lane layout
                  j = b;
               end
            endcase
            scattered[l][b*8 +: 8] = lane_byte_t'(res_i[u][j*8 +: 8]);
         end
      end
   end

   // Slide and ALU results never land in the same cycle
   assign result_o       = slide_vld_i ? slide_res_i : scattered;
   assign result_valid_o = res_vld_i | slide_vld_i;

endmodule

/* design/dpu_slide_xbar.sv */
`include "dpu_config.svh"

module dpu_slide_xbar
   import dpu_data_pkg::*, dpu_op_pkg::*;
(
   input  logic                           clk_i,
   input  logic                           rst_i,
   input  logic                           slide_vld_i,
   input  lane_word_t [`DPU_LANES-1:0]    slide_data_i,
   input  lane_idx_t                      slide_amt_i,
   input  logic [1:0]                     slide_byte_i,
   input  logic                           slide_up_i,
   output logic                           slide_vld_o,
   output lane_word_t [`DPU_LANES-1:0]    slide_res_o
);

   lane_idx_t                   src_lane [`DPU_LANES];
   lane_byte_t                  pick     [`DPU_LANES];
   lane_word_t [`DPU_LANES-1:0] slide_res;

   // Per lane 8:1 mux, source wraps around the array
   always_comb
   begin
      for (int l = 0; l < `DPU_LANES; l++)
      begin
         if (slide_up_i)
            src_lane[l] = lane_idx_t'(l) - slide_amt_i;
         else
            src_lane[l] = lane_idx_t'(l) + slide_amt_i;
         pick[l]      = slide_data_i[src_lane[l]][slide_byte_i*8 +: 8];
         slide_res[l] = {4{pick[l]}};   // Same byte in every position
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
         slide_vld_o <= 1'b0;
      else
         slide_vld_o <= slide_vld_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (slide_vld_i)
         slide_res_o <= slide_res;
   end

endmodule

/* dpu_lane_array.f */
+incdir+design
design/dpu_data_pkg.sv
design/dpu_op_pkg.sv
design/dpu_operand_stage.sv
design/dpu_alu_array.sv
design/dpu_slide_xbar.sv
design/dpu_result_scatter.sv
design/dpu_lane_array.sv
verif/dpu_assertions.sv
verif/dpu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the lane array testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f dpu_lane_array.f --top-module dpu_tb -o Vdpu_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vdpu_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation run returned status $status"
   exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
   exit 1
fi
exit 0

/* verif/dpu_assertions.sv */
`include "dpu_config.svh"

module dpu_assertions
   import dpu_data_pkg::*;
(
   input  logic                           clk_i,
   input  logic                           rst_i,
   input  logic                           issue_i,
   input  sew_t                           sew_i,
   input  logic                           result_valid_i,
   input  lane_word_t [`DPU_LANES-1:0]    result_i
);
   timeunit 1ns;
   timeprecision 100ps;

   ////////////////////////////////////////////////////////////
   // Result timing
   ////////////////////////////////////////////////////////////

   a_issue_to_result: assert property (@(posedge clk_i) disable iff (!rst_i)
      issue_i |-> ##4 result_valid_i)
      else $error("result_valid_o not high four cycles after issue_i");

   // No result without an issue four cycles back
   a_result_from_issue: assert property (@(posedge clk_i) disable iff (!rst_i)
      result_valid_i |-> $past(issue_i, 4))
      else $error("result_valid_o high without issue_i four cycles earlier");

   a_result_known: assert property (@(posedge clk_i) disable iff (!rst_i)
      result_valid_i |-> !$isunknown(result_i))   // Valid data fully defined
      else $error("result_o has unknown bits while result_valid_o is high");

   a_sew_legal: assert property (@(posedge clk_i) disable iff (!rst_i)
      issue_i |-> (sew_i != 2'd3))
      else $error("sew_i is the illegal code 3 on an issue");

endmodule

bind dpu_lane_array dpu_assertions u_assertions (
   .clk_i          (clk_i),
   .rst_i          (rst_i),
   .issue_i        (issue_i),
   .sew_i          (sew_i),
   .result_valid_i (result_valid_o),
   .result_i       (result_o)
);

/* verif/dpu_tb.sv */
`include "dpu_config.svh"

module dpu_tb
   import dpu_data_pkg::*, dpu_op_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   typedef lane_word_t [`DPU_LANES-1:0] words_t;

   // One issued operation with its lane words
   typedef struct packed {
      logic [31:0] issue_edge;
      alu_op_t     op;
      sew_t        sew;
      op2_sel_t    sel;
      lane_word_t  scalar;
      imm_t        imm;
      logic        up;
      words_t      vs1;
      words_t      vs2;
   } op_rec_t;

   logic        clk_i = 1'b0;
   logic        rst_i;
   logic        issue_i;
   alu_op_t     op_i;
   sew_t        sew_i;
   op2_sel_t    op2_sel_i;
   lane_word_t  scalar_i;
   imm_t        imm_i;
   logic        slide_up_i;
   words_t      vs1_i;
   words_t      vs2_i;
   logic        result_valid_o;
   words_t      result_o;

   int          errors = 0;
   int          checks = 0;
   logic [31:0] edge_cnt = '0;     // Rising edges so far
   op_rec_t     exp_q [$];         // Awaiting a result
   op_rec_t     lane_q [$];        // Awaiting their lane words

   dpu_lane_array dut (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .issue_i        (issue_i),
      .op_i           (op_i),
      .sew_i          (sew_i),
      .op2_sel_i      (op2_sel_i),
      .scalar_i       (scalar_i),
      .imm_i          (imm_i),
      .slide_up_i     (slide_up_i),
      .vs1_i          (vs1_i),
      .vs2_i          (vs2_i),
      .result_valid_o (result_valid_o),
      .result_o       (result_o)
   );

   always #2 clk_i = ~clk_i;

   always @(posedge clk_i)
      edge_cnt <= edge_cnt + 32'd1;

   ////////////////////////////////////////////////////////////
   // Reference model on vector byte numbers
   ////////////////////////////////////////////////////////////

   function automatic words_t dpu_model(input op_rec_t r);
      words_t      res;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] y;
      logic [31:0] mask;
      lane_byte_t  pick;
      int          nb;
      int          n;
      int          src;
      res = '0;
      if (r.op == OP_SLIDE)
      begin
         for (int l = 0; l < 8; l++)
         begin
            if (r.up)
               src = (l - int'(r.scalar[2:0]) + 8) % 8;
            else
               src = (l + int'(r.scalar[2:0])) % 8;
            pick   = r.vs2[src][8*r.imm[1:0] +: 8];
            res[l] = {4{pick}};
         end
         return res;
      end
      nb   = 1 << r.sew;   // Bytes per element
      mask = (nb == 4) ? 32'hffff_ffff : (32'd1 << (8 * nb)) - 32'd1;
      for (int e = 0; e < 32 / nb; e++)
      begin
         a = '0;
         b = '0;
         for (int k = 0; k < nb; k++)
         begin
            n            = e * nb + k;   // Lane n%8, byte n/8
            a[8*k +: 8]  = r.vs1[n % 8][8*(n / 8) +: 8];
            b[8*k +: 8]  = r.vs2[n % 8][8*(n / 8) +: 8];
         end
         if (r.sel == OP2_SCALAR)
            b = r.scalar & mask;
         else if (r.sel == OP2_IMM)
            b = 32'(r.imm);
         case (r.op)
            OP_ADD:  y = a + b;
            OP_SUB:  y = a - b;
            OP_AND:  y = a & b;
            OP_OR:   y = a | b;
            OP_XOR:  y = a ^ b;
            default: y = '0;
         endcase
         y = y & mask;   // Wrap within the element
         for (int k = 0; k < nb; k++)
         begin
            n                        = e * nb + k;
            res[n % 8][8*(n / 8) +: 8] = y[8*k +: 8];
         end
      end
      return res;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   // Results come back in issue order
   always @(negedge clk_i)
   begin
      op_rec_t r;
      words_t  exp_w;
      if (rst_i && result_valid_o)
      begin
         if (exp_q.size() == 0)
         begin
            errors++;
            $display("Error at %0t: result_valid_o high with nothing in flight", $time);
         end
         else
         begin
            r     = exp_q.pop_front();
            exp_w = dpu_model(r);
            check_value("result_valid_o latency", edge_cnt - 32'd1 - r.issue_edge, 32'd4);
            for (int l = 0; l < `DPU_LANES; l++)
               check_value($sformatf("result_o[%0d]", l), result_o[l], exp_w[l]);
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////////////////////////

   // Lane words follow their issue by the VRF delay
   task automatic drive_cycle(input logic do_issue, input op_rec_t r);
      op_rec_t rr;
      @(posedge clk_i);
      rr            = r;
      rr.issue_edge = edge_cnt;
      issue_i      <= do_issue;
      if (do_issue)
      begin
         op_i       <= r.op;
         sew_i      <= r.sew;
         op2_sel_i  <= r.sel;
         scalar_i   <= r.scalar;
         imm_i      <= r.imm;
         slide_up_i <= r.up;
         lane_q.push_back(rr);
         exp_q.push_back(rr);
      end
      if (lane_q.size() > 0 && lane_q[0].issue_edge + `DPU_VRF_DELAY == edge_cnt)
      begin
         vs1_i <= lane_q[0].vs1;
         vs2_i <= lane_q[0].vs2;
         lane_q.delete(0);
      end
   endtask

   task automatic drive_idle();
      drive_cycle(1'b0, '0);
   endtask

   task automatic issue_op(input alu_op_t op, input sew_t sew, input op2_sel_t sel,
                           input lane_word_t scalar, input imm_t imm, input logic up,
                           input words_t vs1, input words_t vs2);
      op_rec_t r;
      r        = '0;
      r.op     = op;
      r.sew    = sew;
      r.sel    = sel;
      r.scalar = scalar;
      r.imm    = imm;
      r.up     = up;
      r.vs1    = vs1;
      r.vs2    = vs2;
      drive_cycle(1'b1, r);
   endtask

   function automatic words_t rand_words();
      words_t w;
      for (int l = 0; l < `DPU_LANES; l++)
         w[l] = $urandom;
      return w;
   endfunction

   // Idle cycles until every result is back
   task automatic drain(input string test_name);
      int wait_cnt;
      wait_cnt = 0;
      while ((exp_q.size() != 0 || lane_q.size() != 0) && wait_cnt < 20)
      begin
         drive_idle();
         wait_cnt++;
      end
      if (exp_q.size() != 0)
      begin
         errors++;
         $display("Timeout in %s: %0d results never arrived", test_name, exp_q.size());
         exp_q.delete();
         lane_q.delete();
      end
   endtask

   task automatic report_test(input int num, input string name, input int err_mark);
      $display("Test %0d %s finished with %0d errors", num, name, errors - err_mark);
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////

   initial
   begin
      int err_mark;
      void'($urandom(14057));
      rst_i      = 1'b0;
      issue_i    = 1'b0;
      op_i       = OP_ADD;
      sew_i      = SEW_8;
      op2_sel_i  = OP2_VEC;
      scalar_i   = '0;
      imm_i      = '0;
      slide_up_i = 1'b0;
      vs1_i      = '0;
      vs2_i      = '0;
      repeat (4) @(posedge clk_i);
      rst_i <= 1'b1;

      err_mark = errors;
      for (int i = 0; i < 8; i++)
      begin
         drive_idle();
         @(negedge clk_i);
         check_value("result_valid_o", 32'(result_valid_o), 32'd0);
      end
      report_test(1, "idle after reset", err_mark);

      // All-ones and 0x80 patterns carry out of every byte
      err_mark = errors;
      for (int s = 0; s < 3; s++)
      begin
         issue_op(OP_ADD, sew_t'(s), OP2_VEC, '0, '0, 1'b0,
                  {`DPU_LANES{32'hffff_ffff}}, {`DPU_LANES{32'h0101_0101}});
         issue_op(OP_ADD, sew_t'(s), OP2_VEC, '0, '0, 1'b0,
                  {`DPU_LANES{32'h8080_8080}}, {`DPU_LANES{32'h8080_8080}});
         issue_op(OP_SUB, sew_t'(s), OP2_VEC, '0, '0, 1'b0,
                  {`DPU_LANES{32'h0000_0000}}, {`DPU_LANES{32'h0101_0101}});
         issue_op(OP_SUB, sew_t'(s), OP2_VEC, '0, '0, 1'b0, rand_words(), rand_words());
         issue_op(OP_ADD, sew_t'(s), OP2_VEC, '0, '0, 1'b0, rand_words(), rand_words());
      end
      drain("add and sub carries");
      report_test(2, "add and sub carries", err_mark);

      err_mark = errors;
      for (int s = 0; s < 3; s++)
         for (int o = 0; o < 3; o++)
            issue_op(alu_op_t'(int'(OP_AND) + o), sew_t'(s), OP2_VEC, '0, '0, 1'b0,
                     rand_words(), rand_words());
      drain("logic ops");
      report_test(3, "logic ops", err_mark);

      err_mark = errors;
      for (int s = 0; s < 3; s++)
      begin
         issue_op(OP_ADD, sew_t'(s), OP2_SCALAR, $urandom, '0, 1'b0, rand_words(), '0);
         issue_op(OP_XOR, sew_t'(s), OP2_SCALAR, $urandom, '0, 1'b0, rand_words(), '0);
         issue_op(OP_SUB, sew_t'(s), OP2_IMM, '0, imm_t'($urandom), 1'b0, rand_words(), '0);
         issue_op(OP_OR, sew_t'(s), OP2_IMM, '0, imm_t'($urandom), 1'b0, rand_words(), '0);
      end
      drain("scalar and immediate operands");
      report_test(4, "scalar and immediate operands", err_mark);

      // SEW and select are don't care for a slide
      err_mark = errors;
      for (int i = 0; i < 16; i++)
         issue_op(OP_SLIDE, sew_t'($urandom_range(0, 2)), op2_sel_t'($urandom_range(0, 2)),
                  $urandom, imm_t'($urandom), (i % 2 == 1), rand_words(), rand_words());
      drain("slide up and down");
      report_test(5, "slide up and down", err_mark);

      err_mark = errors;
      for (int i = 0; i < 50; i++)
         issue_op(alu_op_t'($urandom_range(0, 5)), sew_t'($urandom_range(0, 2)),
                  op2_sel_t'($urandom_range(0, 2)), $urandom, imm_t'($urandom),
                  ($urandom_range(0, 1) == 1), rand_words(), rand_words());
      drain("back to back random ops");
      report_test(6, "back to back random ops", err_mark);

      $display("Checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule
